// File: rob_pkg.sv
`default_nettype none

package rob_pkg;

  // -------------------------------------------------------------------------
  // sizes
  // -------------------------------------------------------------------------
  localparam int DISPATCH_WIDTH    = 2;
  localparam int ROB_SIZE          = 8;
  localparam int ROB_ADDR_WIDTH    = 3;
  localparam int ARCH_REGS         = 32;
  localparam int ARCH_ADDR_WIDTH   = 5;
  localparam int PHYS_REGS         = 64;
  localparam int PHYS_ADDR_WIDTH   = 6;
  localparam int RETIRE_DEPTH      = 4;
  localparam int RETIRE_ADDR_WIDTH = 2;

  typedef logic [ARCH_ADDR_WIDTH-1:0] arch_reg_t;
  typedef logic [PHYS_ADDR_WIDTH-1:0] phys_reg_t;

  // -------------------------------------------------------------------------
  // stage to stage payloads
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic [ROB_ADDR_WIDTH-1:0] row;
    logic                      bank;
  } rob_tag_t;

  typedef struct packed {
    logic      valid;
    phys_reg_t phys_rd;
    arch_reg_t arch_rd;
    logic      wb_done;
  } rob_entry_t;

  // one row, index is the bank
  typedef struct packed {
    logic      [DISPATCH_WIDTH-1:0] en;
    arch_reg_t [DISPATCH_WIDTH-1:0] arch_rd;
    phys_reg_t [DISPATCH_WIDTH-1:0] phys_rd;
  } dispatch_row_t;

  typedef struct packed {
    logic     en;
    rob_tag_t tag;
  } wb_req_t;

  typedef struct packed {
    logic      [DISPATCH_WIDTH-1:0] en;
    arch_reg_t [DISPATCH_WIDTH-1:0] arch_rd;
    phys_reg_t [DISPATCH_WIDTH-1:0] phys_rd;
  } commit_row_t;

  typedef struct packed {
    arch_reg_t arch_rd;
    phys_reg_t phys_rd;
    phys_reg_t freed_phys_rd;
  } retire_out_t;

endpackage

`default_nettype wire

// File: rename_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module rename_dispatch (
  input  wire                                                     clk,
  input  wire                                                     rst,
  input  wire                                                     in_valid,
  output logic                                                    in_ready,
  input  wire  [rob_pkg::DISPATCH_WIDTH-1:0]                      in_slot_en,
  input  wire  rob_pkg::arch_reg_t [rob_pkg::DISPATCH_WIDTH-1:0]  in_arch_rd,
  input  wire                                                     row_credit,
  input  wire                                                     free_valid,
  input  wire  rob_pkg::phys_reg_t                                free_phys,
  output logic                                                    dispatch_valid,
  output rob_pkg::dispatch_row_t                                  dispatch_row
);
  import rob_pkg::*;

  // circular free list, sized for every physical register
  phys_reg_t                 free_list [PHYS_REGS];
  phys_reg_t                 rd_ptr;
  phys_reg_t                 wr_ptr;
  logic [PHYS_ADDR_WIDTH:0]  free_cnt;
  logic [ROB_ADDR_WIDTH:0]   row_credits;

  // init walks the registers not taken by the identity map
  logic                      init_busy;
  phys_reg_t                 init_reg;

  logic                      accept;
  logic                      push;
  phys_reg_t                 push_reg;
  logic [1:0]                n_pop;

  assign in_ready = !init_busy && (row_credits != '0) && (free_cnt >= 2);
  assign accept   = in_valid && in_ready;

  // an accepted pair with no enabled slot is dropped
  assign dispatch_valid = accept && (|in_slot_en);

  always_comb begin
    dispatch_row.en         = in_slot_en;
    dispatch_row.arch_rd    = in_arch_rd;
    // bank 1 takes the next register only if bank 0 took one
    dispatch_row.phys_rd[0] = free_list[rd_ptr];
    dispatch_row.phys_rd[1] = free_list[rd_ptr + phys_reg_t'(in_slot_en[0])];
    n_pop = '0;
    if (dispatch_valid) begin
      n_pop = {1'b0, in_slot_en[0]} + {1'b0, in_slot_en[1]};
    end
  end

  // freed registers never arrive while init is running
  assign push     = init_busy || free_valid;
  assign push_reg = init_busy ? init_reg : free_phys;

  always_ff @(posedge clk) begin
    if (push) begin
      free_list[wr_ptr] <= push_reg;
    end
  end

  // -------------------------------------------------------------------------
  // pointers, occupancy and row credits
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy   <= 1'b1;
      init_reg    <= phys_reg_t'(ARCH_REGS);
      rd_ptr      <= '0;
      wr_ptr      <= '0;
      free_cnt    <= '0;
      row_credits <= (ROB_ADDR_WIDTH+1)'(ROB_SIZE);
    end else begin
      if (init_busy) begin
        init_reg <= init_reg + 1'b1;
        if (init_reg == phys_reg_t'(PHYS_REGS-1)) begin
          init_busy <= 1'b0;
        end
      end
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr      <= rd_ptr + phys_reg_t'(n_pop);
      free_cnt    <= free_cnt + (PHYS_ADDR_WIDTH+1)'(push)
                     - (PHYS_ADDR_WIDTH+1)'(n_pop);
      row_credits <= row_credits + (ROB_ADDR_WIDTH+1)'(row_credit)
                     - (ROB_ADDR_WIDTH+1)'(dispatch_valid);
    end
  end

endmodule

`default_nettype wire

// File: rob.sv
`timescale 1ns/10ps
`default_nettype none

module rob (
  input  wire                                                     clk,
  input  wire                                                     rst,
  input  wire                                                     dispatch_valid,
  input  wire  rob_pkg::dispatch_row_t                            dispatch_row,
  output rob_pkg::rob_tag_t  [rob_pkg::DISPATCH_WIDTH-1:0]        dispatch_tag,
  output rob_pkg::phys_reg_t [rob_pkg::DISPATCH_WIDTH-1:0]        dispatch_phys,
  output logic                                                    dispatch_tag_valid,
  input  wire  rob_pkg::wb_req_t [rob_pkg::DISPATCH_WIDTH-1:0]    wb_req,
  input  wire  rob_pkg::phys_reg_t [rob_pkg::DISPATCH_WIDTH-1:0]  query_phys,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0]                      query_ready,
  output logic                                                    row_credit,
  output logic                                                    commit_valid,
  output rob_pkg::commit_row_t                                    commit_row,
  input  wire                                                     retire_credit
);
  import rob_pkg::*;

  rob_entry_t                  entry [ROB_SIZE][DISPATCH_WIDTH];
  // head is the next row to dispatch, tail the next row to commit
  logic [ROB_ADDR_WIDTH-1:0]   head;
  logic [ROB_ADDR_WIDTH-1:0]   tail;
  logic [RETIRE_ADDR_WIDTH:0]  retire_credits;

  logic                        tail_any;
  logic                        tail_done;
  logic [RETIRE_ADDR_WIDTH:0]  tail_count;
  logic                        do_commit;

  // -------------------------------------------------------------------------
  // operand lookup
  // -------------------------------------------------------------------------
  // walk oldest to newest so a younger match overwrites an older one,
  // bank 1 before bank 0 so bank 0 wins within a row
  always_comb begin : lookup
    logic [ROB_ADDR_WIDTH-1:0] r;
    r = '0;
    for (int q = 0; q < DISPATCH_WIDTH; q++) begin
      query_ready[q] = 1'b0;
      for (int j = 0; j < ROB_SIZE; j++) begin
        r = head + ROB_ADDR_WIDTH'(j);
        for (int b = DISPATCH_WIDTH-1; b >= 0; b--) begin
          if (entry[r][b].valid && (entry[r][b].phys_rd == query_phys[q])) begin
            query_ready[q] = entry[r][b].wb_done;
          end
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // commit check on the tail row
  // -------------------------------------------------------------------------
  always_comb begin
    tail_any   = 1'b0;
    tail_done  = 1'b1;
    tail_count = '0;
    for (int b = 0; b < DISPATCH_WIDTH; b++) begin
      if (entry[tail][b].valid) begin
        tail_any   = 1'b1;
        tail_count = tail_count + 1'b1;
        if (!entry[tail][b].wb_done) begin
          tail_done = 1'b0;
        end
      end
    end
  end

  // needs a retire slot for every valid entry of the row
  assign do_commit = tail_any && tail_done && (retire_credits >= tail_count);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < ROB_SIZE; r++) begin
        for (int b = 0; b < DISPATCH_WIDTH; b++) begin
          entry[r][b].valid   <= 1'b0;
          entry[r][b].wb_done <= 1'b0;
        end
      end
    end else begin
      if (dispatch_valid) begin
        for (int b = 0; b < DISPATCH_WIDTH; b++) begin
          entry[head][b] <= '{valid:   dispatch_row.en[b],
                              phys_rd: dispatch_row.phys_rd[b],
                              arch_rd: dispatch_row.arch_rd[b],
                              wb_done: 1'b0};
        end
      end
      for (int b = 0; b < DISPATCH_WIDTH; b++) begin
        if (wb_req[b].en) begin
          entry[wb_req[b].tag.row][wb_req[b].tag.bank].wb_done <= 1'b1;
        end
      end
      if (do_commit) begin
        for (int b = 0; b < DISPATCH_WIDTH; b++) begin
          entry[tail][b].valid <= 1'b0;
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // pointers, credits and pulses
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      head               <= '0;
      tail               <= '0;
      retire_credits     <= (RETIRE_ADDR_WIDTH+1)'(RETIRE_DEPTH);
      dispatch_tag_valid <= 1'b0;
      commit_valid       <= 1'b0;
      row_credit         <= 1'b0;
    end else begin
      dispatch_tag_valid <= dispatch_valid;
      commit_valid       <= do_commit;
      row_credit         <= do_commit;
      if (dispatch_valid) begin
        head <= head + 1'b1;
      end
      if (do_commit) begin
        tail <= tail + 1'b1;
      end
      retire_credits <= retire_credits + (RETIRE_ADDR_WIDTH+1)'(retire_credit)
                        - (do_commit ? tail_count : '0);
    end
  end

  // tag report and commit payload
  always_ff @(posedge clk) begin
    if (dispatch_valid) begin
      for (int b = 0; b < DISPATCH_WIDTH; b++) begin
        dispatch_tag[b].row  <= head;
        dispatch_tag[b].bank <= 1'(b);
        dispatch_phys[b]     <= dispatch_row.phys_rd[b];
      end
    end
    if (do_commit) begin
      for (int b = 0; b < DISPATCH_WIDTH; b++) begin
        commit_row.en[b]      <= entry[tail][b].valid;
        commit_row.arch_rd[b] <= entry[tail][b].arch_rd;
        commit_row.phys_rd[b] <= entry[tail][b].phys_rd;
      end
    end
  end

endmodule

`default_nettype wire

// File: retire_map.sv
`timescale 1ns/10ps
`default_nettype none

module retire_map (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          commit_valid,
  input  wire  rob_pkg::commit_row_t   commit_row,
  output logic                         retire_credit,
  output logic                         retire_valid,
  input  wire                          retire_ready,
  output rob_pkg::retire_out_t         retire_out,
  output logic                         free_valid,
  output rob_pkg::phys_reg_t           free_phys
);
  import rob_pkg::*;

  arch_reg_t                      q_arch [RETIRE_DEPTH];
  phys_reg_t                      q_phys [RETIRE_DEPTH];
  // committed architectural to physical map
  phys_reg_t                      commit_map [ARCH_REGS];

  logic [RETIRE_ADDR_WIDTH-1:0]   rd_ptr;
  logic [RETIRE_ADDR_WIDTH-1:0]   wr_ptr;
  logic [RETIRE_ADDR_WIDTH:0]     count;
  logic                           pop;
  logic [1:0]                     n_push;

  assign retire_valid = (count != '0);
  assign pop          = retire_valid && retire_ready;

  always_comb begin
    retire_out.arch_rd       = q_arch[rd_ptr];
    retire_out.phys_rd       = q_phys[rd_ptr];
    retire_out.freed_phys_rd = commit_map[q_arch[rd_ptr]];
    n_push = '0;
    if (commit_valid) begin
      n_push = {1'b0, commit_row.en[0]} + {1'b0, commit_row.en[1]};
    end
  end

  // enabled banks go in back to back, bank 0 first
  always_ff @(posedge clk) begin : queue_write
    logic [RETIRE_ADDR_WIDTH-1:0] slot;
    slot = wr_ptr;
    if (commit_valid) begin
      for (int b = 0; b < DISPATCH_WIDTH; b++) begin
        if (commit_row.en[b]) begin
          q_arch[slot] <= commit_row.arch_rd[b];
          q_phys[slot] <= commit_row.phys_rd[b];
          slot = slot + 1'b1;
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // drain, map update and freeing
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        commit_map[r] <= phys_reg_t'(r);
      end
      rd_ptr        <= '0;
      wr_ptr        <= '0;
      count         <= '0;
      retire_credit <= 1'b0;
      free_valid    <= 1'b0;
    end else begin
      if (pop) begin
        commit_map[retire_out.arch_rd] <= retire_out.phys_rd;
        rd_ptr <= rd_ptr + 1'b1;
      end
      wr_ptr        <= wr_ptr + RETIRE_ADDR_WIDTH'(n_push);
      count         <= count + (RETIRE_ADDR_WIDTH+1)'(n_push)
                       - (RETIRE_ADDR_WIDTH+1)'(pop);
      retire_credit <= pop;
      free_valid    <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      free_phys <= retire_out.freed_phys_rd;
    end
  end

endmodule

`default_nettype wire

// File: rob_top.sv
`timescale 1ns/10ps
`default_nettype none

module rob_top (
  input  wire                                                     clk,
  input  wire                                                     rst,
  // instruction pairs in
  input  wire                                                     in_valid,
  output logic                                                    in_ready,
  input  wire  [rob_pkg::DISPATCH_WIDTH-1:0]                      in_slot_en,
  input  wire  rob_pkg::arch_reg_t [rob_pkg::DISPATCH_WIDTH-1:0]  in_arch_rd,
  // tags and new phys registers of the last dispatched pair
  output rob_pkg::rob_tag_t  [rob_pkg::DISPATCH_WIDTH-1:0]        dispatch_tag,
  output rob_pkg::phys_reg_t [rob_pkg::DISPATCH_WIDTH-1:0]        dispatch_phys,
  output logic                                                    dispatch_tag_valid,
  // execution side
  input  wire  rob_pkg::wb_req_t [rob_pkg::DISPATCH_WIDTH-1:0]    wb_req,
  input  wire  rob_pkg::phys_reg_t [rob_pkg::DISPATCH_WIDTH-1:0]  query_phys,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0]                      query_ready,
  // retired instructions out
  output logic                                                    retire_valid,
  input  wire                                                     retire_ready,
  output rob_pkg::retire_out_t                                    retire_out
);
  import rob_pkg::*;

  logic          dispatch_valid;
  dispatch_row_t dispatch_row;
  logic          row_credit;
  logic          commit_valid;
  commit_row_t   commit_row;
  logic          retire_credit;
  logic          free_valid;
  phys_reg_t     free_phys;

  rename_dispatch i_rename_dispatch (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_slot_en     (in_slot_en),
    .in_arch_rd     (in_arch_rd),
    .row_credit     (row_credit),
    .free_valid     (free_valid),
    .free_phys      (free_phys),
    .dispatch_valid (dispatch_valid),
    .dispatch_row   (dispatch_row)
  );

  rob i_rob (
    .clk                (clk),
    .rst                (rst),
    .dispatch_valid     (dispatch_valid),
    .dispatch_row       (dispatch_row),
    .dispatch_tag       (dispatch_tag),
    .dispatch_phys      (dispatch_phys),
    .dispatch_tag_valid (dispatch_tag_valid),
    .wb_req             (wb_req),
    .query_phys         (query_phys),
    .query_ready        (query_ready),
    .row_credit         (row_credit),
    .commit_valid       (commit_valid),
    .commit_row         (commit_row),
    .retire_credit      (retire_credit)
  );

  retire_map i_retire_map (
    .clk           (clk),
    .rst           (rst),
    .commit_valid  (commit_valid),
    .commit_row    (commit_row),
    .retire_credit (retire_credit),
    .retire_valid  (retire_valid),
    .retire_ready  (retire_ready),
    .retire_out    (retire_out),
    .free_valid    (free_valid),
    .free_phys     (free_phys)
  );

endmodule

`default_nettype wire

// File: tb_rob_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rob_assertions (
  input wire                        clk,
  input wire                        rst,
  input wire                        dispatch_valid,
  input wire                        row_credit,
  input wire                        commit_valid,
  input wire  rob_pkg::commit_row_t commit_row,
  input wire                        retire_credit,
  input wire                        retire_valid,
  input wire                        retire_ready,
  input wire  rob_pkg::retire_out_t retire_out
);
  import rob_pkg::*;

  // credit counts rebuilt from the pulses between the stages
  int row_credits;
  int retire_credits;
  int fail_count = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      row_credits    <= ROB_SIZE;
      retire_credits <= RETIRE_DEPTH;
    end else begin
      row_credits    <= row_credits + int'(row_credit) - int'(dispatch_valid);
      retire_credits <= retire_credits + int'(retire_credit)
                        - (commit_valid ? $countones(commit_row.en) : 0);
    end
  end

  // -------------------------------------------------------------------------
  // credit bounds and pulses
  // -------------------------------------------------------------------------
  row_credit_range: assert property (@(posedge clk) disable iff (rst)
    row_credits >= 0 && row_credits <= ROB_SIZE)
  else begin
    $error("row credit count out of range");
    fail_count++;
  end

  dispatch_needs_credit: assert property (@(posedge clk) disable iff (rst)
    dispatch_valid |-> row_credits > 0)
  else begin
    $error("dispatch pulse without a row credit");
    fail_count++;
  end

  retire_credit_range: assert property (@(posedge clk) disable iff (rst)
    retire_credits >= 0 && retire_credits <= RETIRE_DEPTH)
  else begin
    $error("retire credit count out of range");
    fail_count++;
  end

  commit_needs_credit: assert property (@(posedge clk) disable iff (rst)
    commit_valid |-> $countones(commit_row.en) <= retire_credits)
  else begin
    $error("commit pulse without enough retire credits");
    fail_count++;
  end

  // -------------------------------------------------------------------------
  // handshakes
  // -------------------------------------------------------------------------
  retire_held: assert property (@(posedge clk) disable iff (rst)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_out))
  else begin
    $error("retire output changed while stalled");
    fail_count++;
  end

endmodule

`default_nettype wire

// File: tb_rob_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rob_top;
  import rob_pkg::*;

  localparam int RANDOM_CYCLES = 3000;
  localparam int WAIT_LIMIT    = 200;
  localparam int DRAIN_LIMIT   = 2000;
  localparam int IDLE_CYCLES   = 16;

  // one instruction as the model sees it
  typedef struct packed {
    arch_reg_t                 arch_rd;
    phys_reg_t                 phys_rd;
    logic [ROB_ADDR_WIDTH-1:0] row;
    logic                      bank;
    logic                      wb_done;
  } model_inst_t;

  logic                              clk = 1'b0;
  logic                              rst;
  logic                              in_valid;
  logic                              in_ready;
  logic [DISPATCH_WIDTH-1:0]         in_slot_en;
  arch_reg_t [DISPATCH_WIDTH-1:0]    in_arch_rd;
  rob_tag_t  [DISPATCH_WIDTH-1:0]    dispatch_tag;
  phys_reg_t [DISPATCH_WIDTH-1:0]    dispatch_phys;
  logic                              dispatch_tag_valid;
  wb_req_t   [DISPATCH_WIDTH-1:0]    wb_req;
  phys_reg_t [DISPATCH_WIDTH-1:0]    query_phys;
  logic [DISPATCH_WIDTH-1:0]         query_ready;
  logic                              retire_valid;
  logic                              retire_ready;
  retire_out_t                       retire_out;

  // reference model
  phys_reg_t                 free_q [$];
  model_inst_t               rob_q [$];
  model_inst_t               prog_q [$];
  rob_tag_t                  open_tags [$];
  phys_reg_t                 commit_map [ARCH_REGS];
  int                        retire_credits_m;
  logic                      credit_pulse;
  logic                      tag_pending;
  model_inst_t               tag_expect [DISPATCH_WIDTH];
  logic [DISPATCH_WIDTH-1:0] tag_expect_en;
  logic [ROB_ADDR_WIDTH-1:0] next_row;
  logic                      stall;
  logic                      saw_backpressure;
  int                        n_dispatched;
  int                        n_retired;
  logic [15:0]               lfsr_state;

  always #10 clk = ~clk;

  rob_top i_dut (
    .clk                (clk),
    .rst                (rst),
    .in_valid           (in_valid),
    .in_ready           (in_ready),
    .in_slot_en         (in_slot_en),
    .in_arch_rd         (in_arch_rd),
    .dispatch_tag       (dispatch_tag),
    .dispatch_phys      (dispatch_phys),
    .dispatch_tag_valid (dispatch_tag_valid),
    .wb_req             (wb_req),
    .query_phys         (query_phys),
    .query_ready        (query_ready),
    .retire_valid       (retire_valid),
    .retire_ready       (retire_ready),
    .retire_out         (retire_out)
  );

  bind rob_top tb_rob_assertions i_assertions (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .row_credit     (row_credit),
    .commit_valid   (commit_valid),
    .commit_row     (commit_row),
    .retire_credit  (retire_credit),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .retire_out     (retire_out)
  );

  // -------------------------------------------------------------------------
  // error handling and random numbers
  // -------------------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compare_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
    if (got !== expected) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
                          $time, what, got, expected));
    end
  endtask

  // 16 bit galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // youngest writer wins and bank 0 goes first within a row
  function automatic logic expected_ready(input phys_reg_t p);
    logic                      found;
    logic                      ready;
    logic [ROB_ADDR_WIDTH-1:0] found_row;
    found     = 1'b0;
    ready     = 1'b0;
    found_row = '0;
    for (int i = rob_q.size() - 1; i >= 0; i--) begin
      if (rob_q[i].phys_rd == p) begin
        if (!found || (rob_q[i].row == found_row && !rob_q[i].bank)) begin
          ready     = rob_q[i].wb_done;
          found_row = rob_q[i].row;
          found     = 1'b1;
        end
      end
    end
    return ready;
  endfunction

  // -------------------------------------------------------------------------
  // per clock edge check outputs, step the model and drive the next inputs
  // -------------------------------------------------------------------------
  task automatic run_cycle(input bit traffic);
    int          n;
    int          k;
    logic        all_done;
    logic        pop;
    model_inst_t inst;
    @(posedge clk);
    if (i_dut.i_assertions.fail_count != 0) begin
      abort_run("a concurrent assertion failed");
    end
    for (int q = 0; q < DISPATCH_WIDTH; q++) begin
      compare_value(query_ready[q], expected_ready(query_phys[q]), "query_ready");
    end
    // tags of the pair accepted one edge ago
    compare_value(dispatch_tag_valid, tag_pending, "dispatch_tag_valid");
    if (tag_pending) begin
      for (int b = 0; b < DISPATCH_WIDTH; b++) begin
        if (tag_expect_en[b]) begin
          compare_value(dispatch_tag[b].row, tag_expect[b].row, "dispatch_tag row");
          compare_value(dispatch_tag[b].bank, tag_expect[b].bank, "dispatch_tag bank");
          compare_value(dispatch_phys[b], tag_expect[b].phys_rd, "dispatch_phys");
          open_tags.push_back(dispatch_tag[b]);
        end
      end
    end
    pop = retire_valid && retire_ready;
    if (pop) begin
      if (prog_q.size() == 0) begin
        abort_run("retire output presented with no instruction outstanding");
      end
      inst = prog_q.pop_front();
      compare_value(retire_out.arch_rd, inst.arch_rd, "retire arch_rd");
      compare_value(retire_out.phys_rd, inst.phys_rd, "retire phys_rd");
      compare_value(retire_out.freed_phys_rd, commit_map[inst.arch_rd], "freed phys_rd");
      free_q.push_back(commit_map[inst.arch_rd]);
      commit_map[inst.arch_rd] = inst.phys_rd;
      n_retired++;
    end
    // oldest row commits once written back and covered by retire credits
    n = 0;
    if (rob_q.size() != 0) begin
      n = 1;
      if (rob_q.size() > 1 && rob_q[1].row == rob_q[0].row) begin
        n = 2;
      end
      all_done = 1'b1;
      for (k = 0; k < n; k++) begin
        if (!rob_q[k].wb_done) begin
          all_done = 1'b0;
        end
      end
      if (!all_done || retire_credits_m < n) begin
        n = 0;
      end
    end
    for (k = 0; k < n; k++) begin
      rob_q.delete(0);
    end
    retire_credits_m = retire_credits_m + int'(credit_pulse) - n;
    credit_pulse     = pop;
    for (int b = 0; b < DISPATCH_WIDTH; b++) begin
      if (wb_req[b].en) begin
        for (k = 0; k < rob_q.size(); k++) begin
          if (rob_q[k].row == wb_req[b].tag.row && rob_q[k].bank == wb_req[b].tag.bank) begin
            rob_q[k].wb_done = 1'b1;
          end
        end
      end
    end
    tag_pending = 1'b0;
    if (in_valid && in_ready) begin
      tag_pending   = 1'b1;
      tag_expect_en = in_slot_en;
      for (int b = 0; b < DISPATCH_WIDTH; b++) begin
        if (in_slot_en[b]) begin
          if (free_q.size() == 0) begin
            abort_run("model free list ran empty");
          end
          inst.arch_rd  = in_arch_rd[b];
          inst.phys_rd  = free_q.pop_front();
          inst.row      = next_row;
          inst.bank     = 1'(b);
          inst.wb_done  = 1'b0;
          tag_expect[b] = inst;
          rob_q.push_back(inst);
          prog_q.push_back(inst);
          n_dispatched++;
        end
      end
      next_row = next_row + 1'b1;
    end
    if (!in_ready && stall) begin
      saw_backpressure = 1'b1;
    end
    // next inputs
    if (traffic) begin
      if (rand_bits(5) == 0) begin
        stall = !stall;
      end
      in_valid      <= (rand_bits(2) != 0);
      k             = rand_bits(2);
      in_slot_en    <= (k == 0) ? 2'b11 : 2'(k);
      in_arch_rd[0] <= arch_reg_t'(rand_bits(5));
      in_arch_rd[1] <= arch_reg_t'(rand_bits(5));
      retire_ready  <= !stall && (rand_bits(2) != 0);
    end else begin
      in_valid     <= 1'b0;
      retire_ready <= 1'b1;
    end
    for (int b = 0; b < DISPATCH_WIDTH; b++) begin
      if (open_tags.size() != 0 && rand_bits(1)) begin
        k = rand_bits(4) % open_tags.size();
        wb_req[b] <= '{en: 1'b1, tag: open_tags[k]};
        open_tags.delete(k);
      end else begin
        wb_req[b] <= '0;
      end
    end
    for (int q = 0; q < DISPATCH_WIDTH; q++) begin
      if (rob_q.size() != 0 && rand_bits(1)) begin
        query_phys[q] <= rob_q[rand_bits(4) % rob_q.size()].phys_rd;
      end else begin
        query_phys[q] <= phys_reg_t'(rand_bits(6));
      end
    end
  endtask

  initial begin
    int waited;
    int quiet;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_slot_en   = '0;
    in_arch_rd   = '0;
    wb_req       = '0;
    query_phys   = '0;
    retire_ready = 1'b0;
    lfsr_state   = 16'd27;
    for (int r = 0; r < ARCH_REGS; r++) begin
      commit_map[r] = phys_reg_t'(r);
    end
    for (int r = ARCH_REGS; r < PHYS_REGS; r++) begin
      free_q.push_back(phys_reg_t'(r));
    end
    retire_credits_m = RETIRE_DEPTH;
    credit_pulse     = 1'b0;
    tag_pending      = 1'b0;
    tag_expect_en    = '0;
    next_row         = '0;
    stall            = 1'b0;
    saw_backpressure = 1'b0;
    n_dispatched     = 0;
    n_retired        = 0;

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // free list fills before the first pair is taken
    waited = 0;
    @(posedge clk);
    while (!in_ready) begin
      compare_value(dispatch_tag_valid, 1'b0, "dispatch_tag_valid after reset");
      compare_value(retire_valid, 1'b0, "retire_valid after reset");
      if (waited == WAIT_LIMIT) begin
        abort_run("timeout waiting for in_ready after reset");
      end
      @(posedge clk);
      waited++;
    end

    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      run_cycle(1'b1);
    end

    // drain until every writeback is issued and the DUT stops retiring
    waited = 0;
    quiet  = 0;
    while (quiet < IDLE_CYCLES) begin
      if (waited == DRAIN_LIMIT) begin
        abort_run("timeout draining outstanding instructions");
      end
      run_cycle(1'b0);
      waited++;
      if (retire_valid || tag_pending || open_tags.size() != 0) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end

    compare_value(n_retired, n_dispatched, "retired count");
    compare_value(saw_backpressure, 1'b1, "in_ready low under back-pressure");
    if (i_dut.i_assertions.fail_count != 0) begin
      abort_run("a concurrent assertion failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim.f
rob_pkg.sv
rename_dispatch.sv
rob.sv
retire_map.sv
rob_top.sv
tb_rob_assertions.sv
tb_rob_top.sv

// File: Bender.yml
package:
  name: rob_top

sources:
  - rob_pkg.sv
  - rename_dispatch.sv
  - rob.sv
  - retire_map.sv
  - rob_top.sv
  - target: test
    files:
      - tb_rob_assertions.sv
      - tb_rob_top.sv
